//--- rv64_isa_pkg.sv
// RV64I instruction definitions
package rv64_isa_pkg;

	typedef logic [5:0]  op_t;
	typedef logic [8:0]  unit_vec_t;
	typedef logic [63:0] xlen_t;
	typedef logic [4:0]  areg_t;

	localparam int AREG_NUM = 32;

	// Execution unit indices
	localparam int U_ADDER  = 0;
	localparam int U_LOGCMP = 1;
	localparam int U_SHIFT  = 2;
	localparam int U_JAL    = 3;
	localparam int U_BRU    = 4;
	localparam int U_LU     = 5;
	localparam int U_SU     = 6;
	localparam int U_FENCE  = 7;
	localparam int U_CSR    = 8;

	// ----------------------------------------
	// Operation codes, grouped by unit
	// ----------------------------------------
	localparam op_t OP_LUI     = 6'd0;
	localparam op_t OP_AUIPC   = 6'd1;
	localparam op_t OP_ADDI    = 6'd2;
	localparam op_t OP_ADDIW   = 6'd3;
	localparam op_t OP_ADD     = 6'd4;
	localparam op_t OP_ADDW    = 6'd5;
	localparam op_t OP_SUB     = 6'd6;
	localparam op_t OP_SUBW    = 6'd7;

	localparam op_t OP_SLTI    = 6'd8;
	localparam op_t OP_SLTIU   = 6'd9;
	localparam op_t OP_SLT     = 6'd10;
	localparam op_t OP_SLTU    = 6'd11;
	localparam op_t OP_XORI    = 6'd12;
	localparam op_t OP_ORI     = 6'd13;
	localparam op_t OP_ANDI    = 6'd14;
	localparam op_t OP_XOR     = 6'd15;
	localparam op_t OP_OR      = 6'd16;
	localparam op_t OP_AND     = 6'd17;

	localparam op_t OP_SLLI    = 6'd18;
	localparam op_t OP_SLLIW   = 6'd19;
	localparam op_t OP_SLL     = 6'd20;
	localparam op_t OP_SLLW    = 6'd21;
	localparam op_t OP_SRLI    = 6'd22;
	localparam op_t OP_SRLIW   = 6'd23;
	localparam op_t OP_SRL     = 6'd24;
	localparam op_t OP_SRLW    = 6'd25;
	localparam op_t OP_SRAI    = 6'd26;
	localparam op_t OP_SRAIW   = 6'd27;
	localparam op_t OP_SRA     = 6'd28;
	localparam op_t OP_SRAW    = 6'd29;

	localparam op_t OP_JAL     = 6'd30;
	localparam op_t OP_JALR    = 6'd31;

	localparam op_t OP_BEQ     = 6'd32;
	localparam op_t OP_BNE     = 6'd33;
	localparam op_t OP_BLT     = 6'd34;
	localparam op_t OP_BGE     = 6'd35;
	localparam op_t OP_BLTU    = 6'd36;
	localparam op_t OP_BGEU    = 6'd37;

	localparam op_t OP_LB      = 6'd38;
	localparam op_t OP_LH      = 6'd39;
	localparam op_t OP_LW      = 6'd40;
	localparam op_t OP_LD      = 6'd41;
	localparam op_t OP_LBU     = 6'd42;
	localparam op_t OP_LHU     = 6'd43;
	localparam op_t OP_LWU     = 6'd44;

	localparam op_t OP_SB      = 6'd45;
	localparam op_t OP_SH      = 6'd46;
	localparam op_t OP_SW      = 6'd47;
	localparam op_t OP_SD      = 6'd48;

	localparam op_t OP_FENCE   = 6'd49;
	localparam op_t OP_FENCE_I = 6'd50;

	localparam op_t OP_CSRRW   = 6'd51;
	localparam op_t OP_CSRRS   = 6'd52;
	localparam op_t OP_CSRRC   = 6'd53;
	localparam op_t OP_CSRRWI  = 6'd54;
	localparam op_t OP_CSRRSI  = 6'd55;
	localparam op_t OP_CSRRCI  = 6'd56;

endpackage

//--- rename_pkg.sv
// Register rename sizes
package rename_pkg;

	// Copies held per architectural register
	localparam int RNDEPTH = 4;
	localparam int RNBIT   = 2;

	localparam int PTAG_W = $bits(rv64_isa_pkg::areg_t) + RNBIT;

	typedef logic [RNBIT-1:0]   copy_t;
	typedef logic [PTAG_W-1:0]  ptag_t;
	typedef logic [RNDEPTH-1:0] copy_mask_t;

	// Micro-instruction queue ahead of dispatch
	localparam int IQ_DEPTH = 4;
	localparam int IQ_PTR_W = 2;

	typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
	typedef logic [IQ_PTR_W:0]   iq_cnt_t;

endpackage

//--- rename_if.sv
// Dispatch to rename link
`timescale 1ns/1ns

interface rename_if;

	// Raw register numbers from dispatch
	rv64_isa_pkg::areg_t rs1_raw;
	rv64_isa_pkg::areg_t rs2_raw;
	rv64_isa_pkg::areg_t rd0_raw;
	logic                rd0_raw_valid;
	logic                rd0_commit;

	// Physical tags back from rename
	rename_pkg::ptag_t rs1_rename;
	rename_pkg::ptag_t rs2_rename;
	rename_pkg::ptag_t rd0_rename;
	logic              rd0_run_out;

	modport dispatch (
		output rs1_raw, rs2_raw, rd0_raw, rd0_raw_valid, rd0_commit,
		input  rs1_rename, rs2_rename, rd0_rename, rd0_run_out
	);

	modport rename (
		input  rs1_raw, rs2_raw, rd0_raw, rd0_raw_valid, rd0_commit,
		output rs1_rename, rs2_rename, rd0_rename, rd0_run_out
	);

endinterface

//--- instr_queue.sv
// Decoded micro-instruction queue
`timescale 1ns/1ns

module instr_queue (
	input  logic                CLK,
	input  logic                rst_n,

	input  logic                push,
	output logic                full,
	input  rv64_isa_pkg::op_t   in_op,
	input  rv64_isa_pkg::xlen_t in_pc,
	input  rv64_isa_pkg::xlen_t in_imm,
	input  rv64_isa_pkg::areg_t in_rd,
	input  rv64_isa_pkg::areg_t in_rs1,
	input  rv64_isa_pkg::areg_t in_rs2,
	input  logic                in_is_rvc,

	input  logic                pop,
	output logic                empty,
	output rv64_isa_pkg::op_t   op,
	output rv64_isa_pkg::xlen_t pc,
	output rv64_isa_pkg::xlen_t imm,
	output rv64_isa_pkg::areg_t rd,
	output rv64_isa_pkg::areg_t rs1,
	output rv64_isa_pkg::areg_t rs2,
	output logic                is_rvc
);

	rv64_isa_pkg::op_t   op_q  [rename_pkg::IQ_DEPTH];
	rv64_isa_pkg::xlen_t pc_q  [rename_pkg::IQ_DEPTH];
	rv64_isa_pkg::xlen_t imm_q [rename_pkg::IQ_DEPTH];
	rv64_isa_pkg::areg_t rd_q  [rename_pkg::IQ_DEPTH];
	rv64_isa_pkg::areg_t rs1_q [rename_pkg::IQ_DEPTH];
	rv64_isa_pkg::areg_t rs2_q [rename_pkg::IQ_DEPTH];
	logic                rvc_q [rename_pkg::IQ_DEPTH];

	rename_pkg::iq_ptr_t rd_ptr;
	rename_pkg::iq_ptr_t wr_ptr;
	rename_pkg::iq_cnt_t count;
	logic                do_push;
	logic                do_pop;

	assign full    = (count == rename_pkg::iq_cnt_t'(rename_pkg::IQ_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + do_push - do_pop;
		end
	end

	// Payload storage
	always_ff @(posedge CLK) begin
		if (do_push) begin
			op_q[wr_ptr]  <= in_op;
			pc_q[wr_ptr]  <= in_pc;
			imm_q[wr_ptr] <= in_imm;
			rd_q[wr_ptr]  <= in_rd;
			rs1_q[wr_ptr] <= in_rs1;
			rs2_q[wr_ptr] <= in_rs2;
			rvc_q[wr_ptr] <= in_is_rvc;
		end
	end

	assign op     = op_q[rd_ptr];
	assign pc     = pc_q[rd_ptr];
	assign imm    = imm_q[rd_ptr];
	assign rd     = rd_q[rd_ptr];
	assign rs1    = rs1_q[rd_ptr];
	assign rs2    = rs2_q[rd_ptr];
	assign is_rvc = rvc_q[rd_ptr];

	a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n) push |-> !full);
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- rename.sv
// Copy-based register rename
`timescale 1ns/1ns

module rename (
	input  logic              CLK,
	input  logic              rst_n,
	rename_if.rename          rn,
	input  logic              commit_valid,
	input  rename_pkg::ptag_t commit_tag
);

	// Used copies and active copy per register
	rename_pkg::copy_mask_t used [rv64_isa_pkg::AREG_NUM];
	rename_pkg::copy_t      act  [rv64_isa_pkg::AREG_NUM];

	rename_pkg::copy_mask_t rd_used;
	rename_pkg::copy_t      free_copy;
	rv64_isa_pkg::areg_t    commit_reg;
	rename_pkg::copy_t      commit_copy;

	assign {commit_reg, commit_copy} = commit_tag;

	// ----------------------------------------
	// Source lookup
	// ----------------------------------------
	assign rn.rs1_rename = {rn.rs1_raw, act[rn.rs1_raw]};
	assign rn.rs2_rename = {rn.rs2_raw, act[rn.rs2_raw]};

	// ----------------------------------------
	// Destination proposal
	// ----------------------------------------
	assign rd_used = used[rn.rd0_raw];

	// Lowest unused copy wins
	always_comb begin
		free_copy = '0;
		for (int i = rename_pkg::RNDEPTH - 1; i >= 0; i--) begin
			if (!rd_used[i])
				free_copy = rename_pkg::copy_t'(i);
		end
	end

	assign rn.rd0_rename  = {rn.rd0_raw, free_copy};
	assign rn.rd0_run_out = rn.rd0_raw_valid & (&rd_used);

	// ----------------------------------------
	// Table update
	// ----------------------------------------
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < rv64_isa_pkg::AREG_NUM; r++) begin
				used[r] <= rename_pkg::copy_mask_t'(1);
				act[r]  <= '0;
			end
		end else begin
			if (commit_valid)
				used[commit_reg][commit_copy] <= 1'b0;
			if (rn.rd0_commit) begin
				used[rn.rd0_raw][free_copy] <= 1'b1;
				act[rn.rd0_raw]             <= free_copy;
			end
		end
	end

	// Released copy must be in use and already superseded
	a_commit_live: assert property (@(posedge CLK) disable iff (!rst_n)
		commit_valid |-> used[commit_reg][commit_copy] && (act[commit_reg] != commit_copy));

endmodule

//--- dispatch.sv
// Unit select, issue and reorder offer
`timescale 1ns/1ns

module dispatch (
	input  logic                    CLK,
	input  logic                    rst_n,

	input  rv64_isa_pkg::op_t       op,
	input  rv64_isa_pkg::xlen_t     pc,
	input  rv64_isa_pkg::xlen_t     imm,
	input  rv64_isa_pkg::areg_t     rd,
	input  rv64_isa_pkg::areg_t     rs1,
	input  rv64_isa_pkg::areg_t     rs2,
	input  logic                    is_rvc,
	input  logic                    empty,
	output logic                    pop,

	rename_if.dispatch              rn,

	output rv64_isa_pkg::unit_vec_t issue_valid,
	input  rv64_isa_pkg::unit_vec_t issue_ready,
	output rv64_isa_pkg::op_t       issue_op,
	output rv64_isa_pkg::xlen_t     issue_pc,
	output rv64_isa_pkg::xlen_t     issue_imm,
	output logic                    issue_is_rvc,
	output rename_pkg::ptag_t       issue_rd_tag,
	output rename_pkg::ptag_t       issue_rs1_tag,
	output rename_pkg::ptag_t       issue_rs2_tag,

	output logic                    rob_valid,
	input  logic                    rob_ready,
	output rv64_isa_pkg::xlen_t     rob_pc,
	output rename_pkg::ptag_t       rob_rd_tag,
	output logic                    rob_rd_valid,
	output logic                    rob_is_branch
);

	rv64_isa_pkg::unit_vec_t unit_sel;
	logic                    writes_rd;
	logic                    head_ok;
	logic                    fire;

	// ----------------------------------------
	// Classification
	// ----------------------------------------
	always_comb begin
		unit_sel  = '0;
		writes_rd = 1'b1;
		case (op)
			rv64_isa_pkg::OP_LUI, rv64_isa_pkg::OP_AUIPC,
			rv64_isa_pkg::OP_ADDI, rv64_isa_pkg::OP_ADDIW,
			rv64_isa_pkg::OP_ADD, rv64_isa_pkg::OP_ADDW,
			rv64_isa_pkg::OP_SUB, rv64_isa_pkg::OP_SUBW:
				unit_sel[rv64_isa_pkg::U_ADDER] = 1'b1;
			rv64_isa_pkg::OP_SLTI, rv64_isa_pkg::OP_SLTIU,
			rv64_isa_pkg::OP_SLT, rv64_isa_pkg::OP_SLTU,
			rv64_isa_pkg::OP_XORI, rv64_isa_pkg::OP_ORI, rv64_isa_pkg::OP_ANDI,
			rv64_isa_pkg::OP_XOR, rv64_isa_pkg::OP_OR, rv64_isa_pkg::OP_AND:
				unit_sel[rv64_isa_pkg::U_LOGCMP] = 1'b1;
			rv64_isa_pkg::OP_SLLI, rv64_isa_pkg::OP_SLLIW,
			rv64_isa_pkg::OP_SLL, rv64_isa_pkg::OP_SLLW,
			rv64_isa_pkg::OP_SRLI, rv64_isa_pkg::OP_SRLIW,
			rv64_isa_pkg::OP_SRL, rv64_isa_pkg::OP_SRLW,
			rv64_isa_pkg::OP_SRAI, rv64_isa_pkg::OP_SRAIW,
			rv64_isa_pkg::OP_SRA, rv64_isa_pkg::OP_SRAW:
				unit_sel[rv64_isa_pkg::U_SHIFT] = 1'b1;
			rv64_isa_pkg::OP_JAL, rv64_isa_pkg::OP_JALR:
				unit_sel[rv64_isa_pkg::U_JAL] = 1'b1;
			rv64_isa_pkg::OP_BEQ, rv64_isa_pkg::OP_BNE,
			rv64_isa_pkg::OP_BLT, rv64_isa_pkg::OP_BGE,
			rv64_isa_pkg::OP_BLTU, rv64_isa_pkg::OP_BGEU: begin
				unit_sel[rv64_isa_pkg::U_BRU] = 1'b1;
				writes_rd                     = 1'b0;
			end
			rv64_isa_pkg::OP_LB, rv64_isa_pkg::OP_LH, rv64_isa_pkg::OP_LW,
			rv64_isa_pkg::OP_LD, rv64_isa_pkg::OP_LBU,
			rv64_isa_pkg::OP_LHU, rv64_isa_pkg::OP_LWU:
				unit_sel[rv64_isa_pkg::U_LU] = 1'b1;
			rv64_isa_pkg::OP_SB, rv64_isa_pkg::OP_SH,
			rv64_isa_pkg::OP_SW, rv64_isa_pkg::OP_SD: begin
				unit_sel[rv64_isa_pkg::U_SU] = 1'b1;
				writes_rd                    = 1'b0;
			end
			rv64_isa_pkg::OP_FENCE, rv64_isa_pkg::OP_FENCE_I: begin
				unit_sel[rv64_isa_pkg::U_FENCE] = 1'b1;
				writes_rd                       = 1'b0;
			end
			rv64_isa_pkg::OP_CSRRW, rv64_isa_pkg::OP_CSRRS, rv64_isa_pkg::OP_CSRRC,
			rv64_isa_pkg::OP_CSRRWI, rv64_isa_pkg::OP_CSRRSI, rv64_isa_pkg::OP_CSRRCI:
				unit_sel[rv64_isa_pkg::U_CSR] = 1'b1;
			default:
				writes_rd = 1'b0;
		endcase
	end

	// ----------------------------------------
	// Rename request and handshake
	// ----------------------------------------
	assign rn.rs1_raw       = rs1;
	assign rn.rs2_raw       = rs2;
	assign rn.rd0_raw       = rd;
	// x0 never takes a copy
	assign rn.rd0_raw_valid = writes_rd & (rd != '0);

	assign head_ok = ~empty & ~rn.rd0_run_out;
	assign fire    = head_ok & (|(unit_sel & issue_ready)) & rob_ready;

	assign pop           = fire;
	assign rn.rd0_commit = fire & rn.rd0_raw_valid;

	assign issue_valid   = head_ok ? unit_sel : '0;
	assign issue_op      = op;
	assign issue_pc      = pc;
	assign issue_imm     = imm;
	assign issue_is_rvc  = is_rvc;
	assign issue_rd_tag  = rn.rd0_rename;
	assign issue_rs1_tag = rn.rs1_rename;
	assign issue_rs2_tag = rn.rs2_rename;

	// Reorder record
	assign rob_valid     = head_ok;
	assign rob_pc        = pc;
	assign rob_rd_tag    = rn.rd0_rename;
	assign rob_rd_valid  = rn.rd0_raw_valid;
	assign rob_is_branch = unit_sel[rv64_isa_pkg::U_BRU] | unit_sel[rv64_isa_pkg::U_JAL];

	a_issue_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0(issue_valid));

endmodule

//--- dispatch_stage.sv
// Rename and dispatch stage top
`timescale 1ns/1ns

module dispatch_stage (
	input  logic                    CLK,
	input  logic                    rst_n,

	// Decoder side
	input  logic                    in_push,
	output logic                    in_full,
	input  rv64_isa_pkg::op_t       in_op,
	input  rv64_isa_pkg::xlen_t     in_pc,
	input  rv64_isa_pkg::xlen_t     in_imm,
	input  rv64_isa_pkg::areg_t     in_rd,
	input  rv64_isa_pkg::areg_t     in_rs1,
	input  rv64_isa_pkg::areg_t     in_rs2,
	input  logic                    in_is_rvc,

	// Issue queues
	output rv64_isa_pkg::unit_vec_t issue_valid,
	input  rv64_isa_pkg::unit_vec_t issue_ready,
	output rv64_isa_pkg::op_t       issue_op,
	output rv64_isa_pkg::xlen_t     issue_pc,
	output rv64_isa_pkg::xlen_t     issue_imm,
	output logic                    issue_is_rvc,
	output rename_pkg::ptag_t       issue_rd_tag,
	output rename_pkg::ptag_t       issue_rs1_tag,
	output rename_pkg::ptag_t       issue_rs2_tag,

	// Reorder buffer
	output logic                    rob_valid,
	input  logic                    rob_ready,
	output rv64_isa_pkg::xlen_t     rob_pc,
	output rename_pkg::ptag_t       rob_rd_tag,
	output logic                    rob_rd_valid,
	output logic                    rob_is_branch,

	input  logic                    commit_valid,
	input  rename_pkg::ptag_t       commit_tag
);

	rv64_isa_pkg::op_t   head_op;
	rv64_isa_pkg::xlen_t head_pc;
	rv64_isa_pkg::xlen_t head_imm;
	rv64_isa_pkg::areg_t head_rd;
	rv64_isa_pkg::areg_t head_rs1;
	rv64_isa_pkg::areg_t head_rs2;
	logic                head_is_rvc;
	logic                q_empty;
	logic                q_pop;

	rename_if rn_if ();

	instr_queue i_queue (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.push      (in_push),
		.full      (in_full),
		.in_op     (in_op),
		.in_pc     (in_pc),
		.in_imm    (in_imm),
		.in_rd     (in_rd),
		.in_rs1    (in_rs1),
		.in_rs2    (in_rs2),
		.in_is_rvc (in_is_rvc),
		.pop       (q_pop),
		.empty     (q_empty),
		.op        (head_op),
		.pc        (head_pc),
		.imm       (head_imm),
		.rd        (head_rd),
		.rs1       (head_rs1),
		.rs2       (head_rs2),
		.is_rvc    (head_is_rvc)
	);

	dispatch i_dispatch (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.op            (head_op),
		.pc            (head_pc),
		.imm           (head_imm),
		.rd            (head_rd),
		.rs1           (head_rs1),
		.rs2           (head_rs2),
		.is_rvc        (head_is_rvc),
		.empty         (q_empty),
		.pop           (q_pop),
		.rn            (rn_if.dispatch),
		.issue_valid   (issue_valid),
		.issue_ready   (issue_ready),
		.issue_op      (issue_op),
		.issue_pc      (issue_pc),
		.issue_imm     (issue_imm),
		.issue_is_rvc  (issue_is_rvc),
		.issue_rd_tag  (issue_rd_tag),
		.issue_rs1_tag (issue_rs1_tag),
		.issue_rs2_tag (issue_rs2_tag),
		.rob_valid     (rob_valid),
		.rob_ready     (rob_ready),
		.rob_pc        (rob_pc),
		.rob_rd_tag    (rob_rd_tag),
		.rob_rd_valid  (rob_rd_valid),
		.rob_is_branch (rob_is_branch)
	);

	rename i_rename (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.rn           (rn_if.rename),
		.commit_valid (commit_valid),
		.commit_tag   (commit_tag)
	);

endmodule

//--- dispatch_stage_tb.sv
// Rename and dispatch testbench
`timescale 1ns/1ns

module dispatch_stage_tb;

	typedef struct packed {
		rv64_isa_pkg::op_t   op;
		rv64_isa_pkg::xlen_t pc;
		rv64_isa_pkg::xlen_t imm;
		rv64_isa_pkg::areg_t rd;
		rv64_isa_pkg::areg_t rs1;
		rv64_isa_pkg::areg_t rs2;
		logic                is_rvc;
	} instr_t;

	localparam int WAIT_LIMIT = 16;
	localparam int INSTR_CYC  = WAIT_LIMIT + 6;
	// 26 instructions over five tests, plus hold checks and reset
	localparam int RUN_CYC    = 26 * INSTR_CYC + 40;
	localparam int WATCHDOG_NS = RUN_CYC * 100 + 2000;

	logic                    CLK;
	logic                    rst_n;
	logic                    in_push;
	logic                    in_full;
	rv64_isa_pkg::op_t       in_op;
	rv64_isa_pkg::xlen_t     in_pc;
	rv64_isa_pkg::xlen_t     in_imm;
	rv64_isa_pkg::areg_t     in_rd;
	rv64_isa_pkg::areg_t     in_rs1;
	rv64_isa_pkg::areg_t     in_rs2;
	logic                    in_is_rvc;
	rv64_isa_pkg::unit_vec_t issue_valid;
	rv64_isa_pkg::unit_vec_t issue_ready;
	rv64_isa_pkg::op_t       issue_op;
	rv64_isa_pkg::xlen_t     issue_pc;
	rv64_isa_pkg::xlen_t     issue_imm;
	logic                    issue_is_rvc;
	rename_pkg::ptag_t       issue_rd_tag;
	rename_pkg::ptag_t       issue_rs1_tag;
	rename_pkg::ptag_t       issue_rs2_tag;
	logic                    rob_valid;
	logic                    rob_ready;
	rv64_isa_pkg::xlen_t     rob_pc;
	rename_pkg::ptag_t       rob_rd_tag;
	logic                    rob_rd_valid;
	logic                    rob_is_branch;
	logic                    commit_valid;
	rename_pkg::ptag_t       commit_tag;

	// Reference rename tables
	rename_pkg::copy_mask_t m_used [rv64_isa_pkg::AREG_NUM];
	rename_pkg::copy_t      m_act  [rv64_isa_pkg::AREG_NUM];

	instr_t              pending [$];
	rv64_isa_pkg::xlen_t next_pc;
	int                  seed;
	int                  errors;
	int                  test_errs;
	int                  checks;
	int                  tests;
	string               test_name;

	dispatch_stage UUT (.*);

	always #50 CLK = ~CLK;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("ERRORS FOUND");
		$finish;
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic int expected_unit(rv64_isa_pkg::op_t op);
		if (op <= rv64_isa_pkg::OP_SUBW)    return rv64_isa_pkg::U_ADDER;
		if (op <= rv64_isa_pkg::OP_AND)     return rv64_isa_pkg::U_LOGCMP;
		if (op <= rv64_isa_pkg::OP_SRAW)    return rv64_isa_pkg::U_SHIFT;
		if (op <= rv64_isa_pkg::OP_JALR)    return rv64_isa_pkg::U_JAL;
		if (op <= rv64_isa_pkg::OP_BGEU)    return rv64_isa_pkg::U_BRU;
		if (op <= rv64_isa_pkg::OP_LWU)     return rv64_isa_pkg::U_LU;
		if (op <= rv64_isa_pkg::OP_SD)      return rv64_isa_pkg::U_SU;
		if (op <= rv64_isa_pkg::OP_FENCE_I) return rv64_isa_pkg::U_FENCE;
		return rv64_isa_pkg::U_CSR;
	endfunction

	function automatic logic writes_dest(int unit);
		return !(unit == rv64_isa_pkg::U_BRU || unit == rv64_isa_pkg::U_SU ||
			unit == rv64_isa_pkg::U_FENCE);
	endfunction

	function automatic rename_pkg::copy_t lowest_free(rv64_isa_pkg::areg_t r);
		rename_pkg::copy_t c;
		logic              found;
		c = '0;
		found = 1'b0;
		for (int i = 0; i < rename_pkg::RNDEPTH; i++) begin
			if (!found && !m_used[r][i]) begin
				c = rename_pkg::copy_t'(i);
				found = 1'b1;
			end
		end
		return c;
	endfunction

	function automatic instr_t make_instr(rv64_isa_pkg::op_t op, rv64_isa_pkg::areg_t rd,
		rv64_isa_pkg::areg_t rs1, rv64_isa_pkg::areg_t rs2);
		instr_t i;
		logic [31:0] r;
		r = $random(seed);
		i.op = op;
		i.pc = next_pc;
		i.imm = {$random(seed), $random(seed)};
		i.rd = rd;
		i.rs1 = rs1;
		i.rs2 = rs2;
		i.is_rvc = r[0];
		next_pc = next_pc + (r[0] ? 64'd2 : 64'd4);
		return i;
	endfunction

	// ----------------------------------------
	// Drive and check helpers
	// ----------------------------------------
	task automatic check_eq(string what, logic [63:0] exp, logic [63:0] act);
		checks++;
		if (exp !== act) begin
			$display("FAILED %s %s expected %0h actual %0h", test_name, what, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic push_instr(instr_t i);
		@(posedge CLK);
		in_push   <= 1'b1;
		in_op     <= i.op;
		in_pc     <= i.pc;
		in_imm    <= i.imm;
		in_rd     <= i.rd;
		in_rs1    <= i.rs1;
		in_rs2    <= i.rs2;
		in_is_rvc <= i.is_rvc;
		pending.push_back(i);
	endtask

	task automatic end_push();
		@(posedge CLK);
		in_push <= 1'b0;
	endtask

	// Waits for the head offer, checks it, then lets it fire
	task automatic expect_dispatch();
		instr_t            e;
		int                unit;
		int                n;
		logic              wr;
		rename_pkg::copy_t fc;
		e = pending.pop_front();
		unit = expected_unit(e.op);
		wr = writes_dest(unit) && (e.rd != 0);
		fc = lowest_free(e.rd);
		n = 0;
		@(negedge CLK);
		while (!rob_valid && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		if (!rob_valid) begin
			$display("%s: instruction at pc %0h was never offered", test_name, e.pc);
			errors++;
			test_errs++;
		end else begin
			check_eq("issue_valid", 64'(9'b1 << unit), 64'(issue_valid));
			check_eq("issue_op", 64'(e.op), 64'(issue_op));
			check_eq("issue_pc", e.pc, issue_pc);
			check_eq("issue_imm", e.imm, issue_imm);
			check_eq("issue_is_rvc", 64'(e.is_rvc), 64'(issue_is_rvc));
			check_eq("issue_rs1_tag", 64'({e.rs1, m_act[e.rs1]}), 64'(issue_rs1_tag));
			check_eq("issue_rs2_tag", 64'({e.rs2, m_act[e.rs2]}), 64'(issue_rs2_tag));
			check_eq("rob_pc", e.pc, rob_pc);
			check_eq("rob_rd_valid", 64'(wr), 64'(rob_rd_valid));
			check_eq("rob_is_branch", 64'(unit == rv64_isa_pkg::U_BRU ||
				unit == rv64_isa_pkg::U_JAL), 64'(rob_is_branch));
			if (wr) begin
				check_eq("issue_rd_tag", 64'({e.rd, fc}), 64'(issue_rd_tag));
				check_eq("rob_rd_tag", 64'({e.rd, fc}), 64'(rob_rd_tag));
			end
			@(posedge CLK);
			rob_ready <= 1'b1;
			@(posedge CLK);
			rob_ready <= 1'b0;
			if (wr) begin
				m_used[e.rd][fc] = 1'b1;
				m_act[e.rd] = fc;
			end
		end
	endtask

	task automatic hold_check(rv64_isa_pkg::unit_vec_t exp_valid, logic exp_rob, int cycles);
		instr_t h;
		h = pending[0];
		repeat (cycles) begin
			@(negedge CLK);
			check_eq("held issue_valid", 64'(exp_valid), 64'(issue_valid));
			check_eq("held rob_valid", 64'(exp_rob), 64'(rob_valid));
			check_eq("held issue_pc", h.pc, issue_pc);
			check_eq("held issue_op", 64'(h.op), 64'(issue_op));
		end
	endtask

	task automatic commit_copy(rv64_isa_pkg::areg_t r, rename_pkg::copy_t c);
		@(posedge CLK);
		commit_valid <= 1'b1;
		commit_tag   <= {r, c};
		@(posedge CLK);
		commit_valid <= 1'b0;
		m_used[r][c] = 1'b0;
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_errs = 0;
		tests++;
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", test_name, test_errs);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic test_classification();
		rv64_isa_pkg::op_t   ops [9];
		rv64_isa_pkg::areg_t rd;
		start_test("classification");
		ops = '{rv64_isa_pkg::OP_ADDI, rv64_isa_pkg::OP_XOR, rv64_isa_pkg::OP_SRAI,
			rv64_isa_pkg::OP_JALR, rv64_isa_pkg::OP_BNE, rv64_isa_pkg::OP_LD,
			rv64_isa_pkg::OP_SW, rv64_isa_pkg::OP_FENCE, rv64_isa_pkg::OP_CSRRS};
		for (int i = 0; i < 9; i++) begin
			// Separate register pair per class
			rd = rv64_isa_pkg::areg_t'(1 + 3 * i + ($random(seed) & 1));
			push_instr(make_instr(ops[i], rd, rv64_isa_pkg::areg_t'($random(seed)),
				rv64_isa_pkg::areg_t'($random(seed))));
			end_push();
			expect_dispatch();
		end
		end_test();
	endtask

	task automatic test_renaming();
		start_test("renaming");
		for (int i = 0; i < 3; i++) begin
			push_instr(make_instr(rv64_isa_pkg::OP_ADD, 5'd28, 5'd28, 5'd27));
			end_push();
			expect_dispatch();
		end
		end_test();
	endtask

	task automatic test_run_out();
		start_test("run_out");
		for (int i = 0; i < 3; i++) begin
			push_instr(make_instr(rv64_isa_pkg::OP_ADDI, 5'd30, 5'd30, 5'd0));
			end_push();
			expect_dispatch();
		end
		push_instr(make_instr(rv64_isa_pkg::OP_ADDI, 5'd30, 5'd30, 5'd0));
		end_push();
		// Every ready high, only run out holds the head
		rob_ready <= 1'b1;
		hold_check('0, 1'b0, 4);
		@(posedge CLK);
		rob_ready <= 1'b0;
		commit_copy(5'd30, 2'd1);
		expect_dispatch();
		end_test();
	endtask

	task automatic test_back_pressure();
		rv64_isa_pkg::unit_vec_t adder;
		start_test("back_pressure");
		adder = rv64_isa_pkg::unit_vec_t'(1) << rv64_isa_pkg::U_ADDER;
		@(posedge CLK);
		issue_ready <= ~adder;
		rob_ready   <= 1'b1;
		for (int i = 0; i < 4; i++)
			push_instr(make_instr(rv64_isa_pkg::OP_ADD, rv64_isa_pkg::areg_t'(21 + i),
				rv64_isa_pkg::areg_t'(i), rv64_isa_pkg::areg_t'(21 + i)));
		end_push();
		@(negedge CLK);
		check_eq("in_full", 64'd1, 64'(in_full));
		hold_check(adder, 1'b1, 3);
		@(posedge CLK);
		issue_ready <= '1;
		rob_ready   <= 1'b0;
		hold_check(adder, 1'b1, 3);
		check_eq("in_full", 64'd1, 64'(in_full));
		repeat (4)
			expect_dispatch();
		end_test();
	endtask

	task automatic test_no_dest();
		start_test("no_destination");
		push_instr(make_instr(rv64_isa_pkg::OP_BEQ, 5'd5, 5'd5, 5'd7));
		push_instr(make_instr(rv64_isa_pkg::OP_SD, 5'd7, 5'd5, 5'd7));
		push_instr(make_instr(rv64_isa_pkg::OP_FENCE, 5'd9, 5'd0, 5'd0));
		push_instr(make_instr(rv64_isa_pkg::OP_ADDI, 5'd0, 5'd9, 5'd0));
		end_push();
		repeat (4)
			expect_dispatch();
		push_instr(make_instr(rv64_isa_pkg::OP_JAL, 5'd0, 5'd0, 5'd0));
		// Reads and writes the registers above
		push_instr(make_instr(rv64_isa_pkg::OP_ADD, 5'd5, 5'd7, 5'd9));
		end_push();
		repeat (2)
			expect_dispatch();
		end_test();
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		in_push = 1'b0;
		in_op = '0;
		in_pc = '0;
		in_imm = '0;
		in_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_is_rvc = 1'b0;
		issue_ready = '1;
		rob_ready = 1'b0;
		commit_valid = 1'b0;
		commit_tag = '0;
		seed = 68976;
		errors = 0;
		checks = 0;
		tests = 0;
		next_pc = 64'h8000_0000;
		for (int r = 0; r < rv64_isa_pkg::AREG_NUM; r++) begin
			m_used[r] = rename_pkg::copy_mask_t'(1);
			m_act[r] = '0;
		end
		repeat (2) @(posedge CLK);
		rst_n <= 1'b1;
		test_classification();
		test_renaming();
		test_run_out();
		test_back_pressure();
		test_no_dest();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
rv64_isa_pkg.sv
rename_pkg.sv
rename_if.sv
instr_queue.sv
rename.sv
dispatch.sv
dispatch_stage.sv
dispatch_stage_tb.sv

//--- Makefile
SIM = obj_dir/Vdispatch_stage_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): list.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module dispatch_stage_tb -o Vdispatch_stage_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
